//--- Makefile
TB_TOP = lsu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TB_TOP) -f lsu_top.f

sim:
	verilator --binary --timing --assert --top-module $(TB_TOP) -f lsu_top.f -o lsu_sim
	./obj_dir/lsu_sim | tee sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hdl/amo_alu.sv
`timescale 1ns/100ps

module amo_alu (
    input  lsu_pkg::amo_op_t         amo_op_i,
    input  logic [lsu_pkg::XLEN-1:0] amo_src_i,
    input  logic [lsu_pkg::XLEN-1:0] amo_rdata_i,
    output logic [lsu_pkg::XLEN-1:0] amo_wdata_o
);

import lsu_pkg::*;

logic src_lt_signed;
logic src_lt_unsigned;

assign src_lt_signed   = $signed(amo_src_i) < $signed(amo_rdata_i);
assign src_lt_unsigned = amo_src_i < amo_rdata_i;

always_comb begin
    case (amo_op_i)
        AMO_SWAP: amo_wdata_o = amo_src_i;
        AMO_ADD:  amo_wdata_o = amo_rdata_i + amo_src_i;
        AMO_XOR:  amo_wdata_o = amo_rdata_i ^ amo_src_i;
        AMO_AND:  amo_wdata_o = amo_rdata_i & amo_src_i;
        AMO_OR:   amo_wdata_o = amo_rdata_i | amo_src_i;
        AMO_MIN:  amo_wdata_o = src_lt_signed ? amo_src_i : amo_rdata_i;
        AMO_MAX:  amo_wdata_o = src_lt_signed ? amo_rdata_i : amo_src_i;
        AMO_MINU: amo_wdata_o = src_lt_unsigned ? amo_src_i : amo_rdata_i;
        AMO_MAXU: amo_wdata_o = src_lt_unsigned ? amo_rdata_i : amo_src_i;
        default:  amo_wdata_o = amo_src_i;
    endcase
end

endmodule

//--- hdl/dmem_model.sv
`timescale 1ns/100ps

module dmem_model (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         req_i,
    input  logic                         wr_i,
    input  logic [lsu_pkg::ADDR_LEN-1:2] addr_i,
    input  logic [lsu_pkg::BYTE_LEN-1:0] byte_i,
    input  logic [lsu_pkg::XLEN-1:0]     wdata_i,
    output logic                         busy_o,
    output logic [lsu_pkg::XLEN-1:0]     rdata_o,
    output logic [mem_pkg::BAD_LEN-1:0]  bad_o
);

import lsu_pkg::*;
import mem_pkg::*;

logic [XLEN-1:0]         mem [DMEM_WORDS];
logic [WAIT_CNT_LEN-1:0] wait_cnt;
logic [DMEM_IDX_LEN-1:0] idx;
logic                    accept;
logic                    in_range;
logic                    in_ro;

assign accept   = req_i & ~busy_o;
assign idx      = addr_i[DMEM_IDX_LEN+1:2];
assign in_range = (addr_i[ADDR_LEN-1:DMEM_IDX_LEN+2] == '0);
assign in_ro    = ({addr_i, 2'b00} >= RO_BASE) && ({addr_i, 2'b00} <= RO_LIMIT);
assign busy_o   = (wait_cnt != '0);

always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        wait_cnt <= '0;
        bad_o    <= '0;
    end
    else if (accept) begin
        wait_cnt         <= WAIT_CNT_LEN'(MEM_WAIT);
        bad_o[BAD_RANGE] <= ~in_range;
        bad_o[BAD_PROT]  <= in_range & wr_i & in_ro;
    end
    else if (busy_o) begin
        wait_cnt <= wait_cnt - 1'b1;
    end
end

// the array comes out of reset zeroed.
always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] <= '0;
        end
    end
    else if (accept && wr_i && in_range && !in_ro) begin
        for (int b = 0; b < BYTE_LEN; b++) begin
            if (byte_i[b]) begin
                mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (accept) begin
        rdata_o <= in_range ? mem[idx] : '0;
    end
end

endmodule

//--- hdl/lsu_access.sv
`timescale 1ns/100ps

module lsu_access (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          s1_valid_i,
    input  logic [lsu_pkg::ADDR_LEN-1:0]  s1_addr_i,
    input  logic [lsu_pkg::BYTE_LEN-1:0]  s1_byte_i,
    input  logic [lsu_pkg::XLEN-1:0]      s1_wdata_i,
    input  lsu_pkg::size_t                s1_size_i,
    input  logic                          s1_sign_i,
    input  logic                          s1_wr_i,
    input  logic                          s1_amo_i,
    input  lsu_pkg::amo_op_t              s1_amo_op_i,
    input  logic                          s1_lr_i,
    input  logic                          s1_sc_i,
    input  logic                          s1_misaligned_i,
    input  logic [lsu_pkg::XLEN-1:0]      amo_wdata_i,
    input  logic                          dmem_busy_i,
    input  logic [lsu_pkg::XLEN-1:0]      dmem_rdata_i,
    input  logic [mem_pkg::BAD_LEN-1:0]   dmem_bad_i,
    output lsu_pkg::amo_op_t              amo_op_o,
    output logic [lsu_pkg::XLEN-1:0]      amo_src_o,
    output logic [lsu_pkg::XLEN-1:0]      amo_rdata_o,
    output logic                          dmem_req_o,
    output logic                          dmem_wr_o,
    output logic [lsu_pkg::ADDR_LEN-1:2]  dmem_addr_o,
    output logic [lsu_pkg::BYTE_LEN-1:0]  dmem_byte_o,
    output logic [lsu_pkg::XLEN-1:0]      dmem_wdata_o,
    output logic                          busy_o,
    output logic                          s2_valid_o,
    output logic [lsu_pkg::XLEN-1:0]      s2_rdata_o,
    output logic [1:0]                    s2_low_o,
    output lsu_pkg::size_t                s2_size_o,
    output logic                          s2_sign_o,
    output logic                          s2_sc_o,
    output logic                          s2_sc_fail_o,
    output lsu_pkg::cause_t               s2_cause_o
);

import lsu_pkg::*;
import mem_pkg::*;

typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT
} state_t;

state_t              state;
logic [ADDR_LEN-1:2] addr_q;
logic [1:0]          low_q;
logic [BYTE_LEN-1:0] byte_q;
logic [XLEN-1:0]     wdata_q;
size_t               size_q;
logic                sign_q;
logic                wr_q;
logic                amo_q;
amo_op_t             amo_op_q;
logic                lr_q;
logic                sc_q;
logic                misaligned_q;
logic                sc_fail_q;
logic                amo_wr_q;
logic [XLEN-1:0]     rdata_q;
logic                resv_valid;
logic [ADDR_LEN-1:2] resv_addr;
logic                resv_hit;
logic                kill;
logic                mem_done;
logic                amo_go;
cause_t              cause;

assign resv_hit = resv_valid && (resv_addr == s1_addr_i[ADDR_LEN-1:2]);
assign kill     = misaligned_q | sc_fail_q;
assign mem_done = (state == ST_WAIT) & ~dmem_busy_i;

// the AMO write goes out in the same cycle its read data comes back.
assign amo_go = mem_done & amo_q & ~amo_wr_q & ~kill & ~|dmem_bad_i;

// ------------------------------
// memory side
// ------------------------------
assign dmem_req_o   = ((state == ST_ISSUE) & ~kill) | amo_go;
assign dmem_wr_o    = amo_q ? amo_go : wr_q;
assign dmem_addr_o  = addr_q;
assign dmem_byte_o  = amo_q ? BE_WORD : byte_q;
assign dmem_wdata_o = amo_q ? amo_wdata_i : wdata_q;

assign amo_op_o    = amo_op_q;
assign amo_src_o   = wdata_q;
assign amo_rdata_o = dmem_rdata_i;

assign busy_o = s1_valid_i | (state != ST_IDLE);

// ------------------------------
// stage 3 side
// ------------------------------
assign s2_valid_o   = mem_done & ~amo_go;
assign s2_rdata_o   = amo_q ? rdata_q : (wr_q ? '0 : dmem_rdata_i);
assign s2_low_o     = low_q;
assign s2_size_o    = size_q;
assign s2_sign_o    = sign_q;
assign s2_sc_o      = sc_q;
assign s2_sc_fail_o = sc_fail_q;
assign s2_cause_o   = cause;

// AMOs report like stores.
always_comb begin
    if (misaligned_q) begin
        cause = (wr_q | amo_q) ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED;
    end
    else if (sc_fail_q) begin
        cause = CAUSE_NONE;
    end
    else if (dmem_bad_i[BAD_RANGE]) begin
        cause = (wr_q | amo_q) ? CAUSE_STORE_ACCESS : CAUSE_LOAD_ACCESS;
    end
    else if (dmem_bad_i[BAD_PROT]) begin
        cause = CAUSE_STORE_PROTECT;
    end
    else begin
        cause = CAUSE_NONE;
    end
end

always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        state    <= ST_IDLE;
        amo_wr_q <= 1'b0;
    end
    else begin
        case (state)
            ST_IDLE: begin
                if (s1_valid_i) state <= ST_ISSUE;
            end
            ST_ISSUE: begin
                if (kill || !dmem_busy_i) state <= ST_WAIT;
            end
            default: begin
                if (amo_go) begin
                    amo_wr_q <= 1'b1;
                end
                else if (mem_done) begin
                    state    <= ST_IDLE;
                    amo_wr_q <= 1'b0;
                end
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (s1_valid_i && (state == ST_IDLE)) begin
        addr_q       <= s1_addr_i[ADDR_LEN-1:2];
        low_q        <= s1_addr_i[1:0];
        byte_q       <= s1_byte_i;
        wdata_q      <= s1_wdata_i;
        size_q       <= s1_size_i;
        sign_q       <= s1_sign_i;
        wr_q         <= s1_wr_i | s1_sc_i;
        amo_q        <= s1_amo_i;
        amo_op_q     <= s1_amo_op_i;
        lr_q         <= s1_lr_i;
        sc_q         <= s1_sc_i;
        misaligned_q <= s1_misaligned_i;
        sc_fail_q    <= s1_sc_i & ~resv_hit;
    end
    if (amo_go) begin
        rdata_q <= dmem_rdata_i;
    end
end

// the reservation drops on any SC and on any store to the reserved word.
always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        resv_valid <= 1'b0;
    end
    else if (s1_valid_i && (s1_sc_i || ((s1_wr_i || s1_amo_i) && resv_hit))) begin
        resv_valid <= 1'b0;
    end
    else if (s2_valid_o && lr_q && (cause == CAUSE_NONE)) begin
        resv_valid <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (s2_valid_o && lr_q) begin
        resv_addr <= addr_q;
    end
end

endmodule

//--- hdl/lsu_align.sv
`timescale 1ns/100ps

module lsu_align (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         req_i,
    input  logic                         wr_i,
    input  lsu_pkg::size_t               size_i,
    input  logic                         sign_ext_i,
    input  logic                         amo_i,
    input  logic                         lr_i,
    input  logic                         sc_i,
    input  lsu_pkg::amo_op_t             amo_op_i,
    input  logic [lsu_pkg::ADDR_LEN-1:0] addr_i,
    input  logic [lsu_pkg::XLEN-1:0]     wdata_i,
    output logic                         s1_valid_o,
    output logic [lsu_pkg::ADDR_LEN-1:0] s1_addr_o,
    output logic [lsu_pkg::BYTE_LEN-1:0] s1_byte_o,
    output logic [lsu_pkg::XLEN-1:0]     s1_wdata_o,
    output lsu_pkg::size_t               s1_size_o,
    output logic                         s1_sign_o,
    output logic                         s1_wr_o,
    output logic                         s1_amo_o,
    output lsu_pkg::amo_op_t             s1_amo_op_o,
    output logic                         s1_lr_o,
    output logic                         s1_sc_o,
    output logic                         s1_misaligned_o
);

import lsu_pkg::*;

logic [BYTE_LEN-1:0] byte_en;
logic                misaligned;

always_comb begin
    case (size_i)
        SIZE_BYTE: byte_en = BE_BYTE;
        SIZE_HALF: byte_en = BE_HALF;
        default:   byte_en = BE_WORD;
    endcase
end

assign misaligned = ((size_i == SIZE_HALF) && addr_i[0]) ||
                    ((size_i == SIZE_WORD) && (addr_i[1:0] != 2'b00));

always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        s1_valid_o <= 1'b0;
    end
    else begin
        s1_valid_o <= req_i;
    end
end

// an aligned access never wraps past lane 3, so shifting by the low bits
// lands every byte on its memory lane.
always_ff @(posedge clk) begin
    if (req_i) begin
        s1_addr_o       <= addr_i;
        s1_byte_o       <= byte_en << addr_i[1:0];
        s1_wdata_o      <= wdata_i << {addr_i[1:0], 3'b000};
        s1_size_o       <= size_i;
        s1_sign_o       <= sign_ext_i;
        s1_wr_o         <= wr_i;
        s1_amo_o        <= amo_i;
        s1_amo_op_o     <= amo_op_i;
        s1_lr_o         <= lr_i;
        s1_sc_o         <= sc_i;
        s1_misaligned_o <= misaligned;
    end
end

endmodule

//--- hdl/lsu_format.sv
`timescale 1ns/100ps

module lsu_format (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     s2_valid_i,
    input  logic [lsu_pkg::XLEN-1:0] s2_rdata_i,
    input  logic [1:0]               s2_low_i,
    input  lsu_pkg::size_t           s2_size_i,
    input  logic                     s2_sign_i,
    input  logic                     s2_sc_i,
    input  logic                     s2_sc_fail_i,
    input  lsu_pkg::cause_t          s2_cause_i,
    output logic                     rsp_valid_o,
    output logic [lsu_pkg::XLEN-1:0] rdata_o,
    output logic                     fault_o,
    output lsu_pkg::cause_t          cause_o
);

import lsu_pkg::*;

logic [XLEN-1:0] lane_data;
logic [XLEN-1:0] load_data;
logic            fault;

assign lane_data = s2_rdata_i >> {s2_low_i, 3'b000};
assign fault     = (s2_cause_i != CAUSE_NONE);

always_comb begin
    case (s2_size_i)
        SIZE_BYTE: load_data = {{XLEN-8{s2_sign_i & lane_data[7]}}, lane_data[7:0]};
        SIZE_HALF: load_data = {{XLEN-16{s2_sign_i & lane_data[15]}}, lane_data[15:0]};
        default:   load_data = lane_data;
    endcase
end

always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        rsp_valid_o <= 1'b0;
        fault_o     <= 1'b0;
        cause_o     <= CAUSE_NONE;
    end
    else begin
        rsp_valid_o <= s2_valid_i;
        fault_o     <= s2_valid_i & fault;
        cause_o     <= s2_valid_i ? s2_cause_i : CAUSE_NONE;
    end
end

// an SC answers 0 when it stored and 1 when it did not.
always_ff @(posedge clk) begin
    if (s2_valid_i) begin
        if (fault) begin
            rdata_o <= '0;
        end
        else if (s2_sc_i) begin
            rdata_o <= {{XLEN-1{1'b0}}, s2_sc_fail_i};
        end
        else begin
            rdata_o <= load_data;
        end
    end
end

endmodule

//--- hdl/lsu_pkg.sv
package lsu_pkg;

localparam int XLEN       = 32;
localparam int ADDR_LEN   = 12;
localparam int BYTE_LEN   = 4;
localparam int AMO_OP_LEN = 4;

typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
} size_t;

// byte enables of each size on lane 0, before the lane rotation.
localparam logic [BYTE_LEN-1:0] BE_BYTE = 4'b0001;
localparam logic [BYTE_LEN-1:0] BE_HALF = 4'b0011;
localparam logic [BYTE_LEN-1:0] BE_WORD = 4'b1111;

typedef enum logic [AMO_OP_LEN-1:0] {
    AMO_SWAP = 4'd0,
    AMO_ADD  = 4'd1,
    AMO_XOR  = 4'd2,
    AMO_AND  = 4'd3,
    AMO_OR   = 4'd4,
    AMO_MIN  = 4'd5,
    AMO_MAX  = 4'd6,
    AMO_MINU = 4'd7,
    AMO_MAXU = 4'd8
} amo_op_t;

typedef enum logic [2:0] {
    CAUSE_NONE             = 3'd0,
    CAUSE_LOAD_MISALIGNED  = 3'd1,
    CAUSE_STORE_MISALIGNED = 3'd2,
    CAUSE_LOAD_ACCESS      = 3'd3,
    CAUSE_STORE_ACCESS     = 3'd4,
    CAUSE_STORE_PROTECT    = 3'd5
} cause_t;

endpackage

//--- hdl/lsu_top.sv
`timescale 1ns/100ps

module lsu_top (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         req_i,
    input  logic                         wr_i,
    input  lsu_pkg::size_t               size_i,
    input  logic                         sign_ext_i,
    input  logic                         amo_i,
    input  logic                         lr_i,
    input  logic                         sc_i,
    input  lsu_pkg::amo_op_t             amo_op_i,
    input  logic [lsu_pkg::ADDR_LEN-1:0] addr_i,
    input  logic [lsu_pkg::XLEN-1:0]     wdata_i,
    output logic                         busy_o,
    output logic                         rsp_valid_o,
    output logic [lsu_pkg::XLEN-1:0]     rdata_o,
    output logic                         fault_o,
    output lsu_pkg::cause_t              cause_o
);

import lsu_pkg::*;
import mem_pkg::*;

logic                s1_valid;
logic [ADDR_LEN-1:0] s1_addr;
logic [BYTE_LEN-1:0] s1_byte;
logic [XLEN-1:0]     s1_wdata;
size_t               s1_size;
logic                s1_sign;
logic                s1_wr;
logic                s1_amo;
amo_op_t             s1_amo_op;
logic                s1_lr;
logic                s1_sc;
logic                s1_misaligned;

amo_op_t             amo_op;
logic [XLEN-1:0]     amo_src;
logic [XLEN-1:0]     amo_rdata;
logic [XLEN-1:0]     amo_wdata;

logic                dmem_req;
logic                dmem_wr;
logic [ADDR_LEN-1:2] dmem_addr;
logic [BYTE_LEN-1:0] dmem_byte;
logic [XLEN-1:0]     dmem_wdata;
logic                dmem_busy;
logic [XLEN-1:0]     dmem_rdata;
logic [BAD_LEN-1:0]  dmem_bad;

logic                s2_valid;
logic [XLEN-1:0]     s2_rdata;
logic [1:0]          s2_low;
size_t               s2_size;
logic                s2_sign;
logic                s2_sc;
logic                s2_sc_fail;
cause_t              s2_cause;

lsu_align u_align (
    .clk             ( clk           ),
    .rstn            ( rstn          ),
    .req_i           ( req_i         ),
    .wr_i            ( wr_i          ),
    .size_i          ( size_i        ),
    .sign_ext_i      ( sign_ext_i    ),
    .amo_i           ( amo_i         ),
    .lr_i            ( lr_i          ),
    .sc_i            ( sc_i          ),
    .amo_op_i        ( amo_op_i      ),
    .addr_i          ( addr_i        ),
    .wdata_i         ( wdata_i       ),
    .s1_valid_o      ( s1_valid      ),
    .s1_addr_o       ( s1_addr       ),
    .s1_byte_o       ( s1_byte       ),
    .s1_wdata_o      ( s1_wdata      ),
    .s1_size_o       ( s1_size       ),
    .s1_sign_o       ( s1_sign       ),
    .s1_wr_o         ( s1_wr         ),
    .s1_amo_o        ( s1_amo        ),
    .s1_amo_op_o     ( s1_amo_op     ),
    .s1_lr_o         ( s1_lr         ),
    .s1_sc_o         ( s1_sc         ),
    .s1_misaligned_o ( s1_misaligned )
);

lsu_access u_access (
    .clk             ( clk           ),
    .rstn            ( rstn          ),
    .s1_valid_i      ( s1_valid      ),
    .s1_addr_i       ( s1_addr       ),
    .s1_byte_i       ( s1_byte       ),
    .s1_wdata_i      ( s1_wdata      ),
    .s1_size_i       ( s1_size       ),
    .s1_sign_i       ( s1_sign       ),
    .s1_wr_i         ( s1_wr         ),
    .s1_amo_i        ( s1_amo        ),
    .s1_amo_op_i     ( s1_amo_op     ),
    .s1_lr_i         ( s1_lr         ),
    .s1_sc_i         ( s1_sc         ),
    .s1_misaligned_i ( s1_misaligned ),
    .amo_wdata_i     ( amo_wdata     ),
    .dmem_busy_i     ( dmem_busy     ),
    .dmem_rdata_i    ( dmem_rdata    ),
    .dmem_bad_i      ( dmem_bad      ),
    .amo_op_o        ( amo_op        ),
    .amo_src_o       ( amo_src       ),
    .amo_rdata_o     ( amo_rdata     ),
    .dmem_req_o      ( dmem_req      ),
    .dmem_wr_o       ( dmem_wr       ),
    .dmem_addr_o     ( dmem_addr     ),
    .dmem_byte_o     ( dmem_byte     ),
    .dmem_wdata_o    ( dmem_wdata    ),
    .busy_o          ( busy_o        ),
    .s2_valid_o      ( s2_valid      ),
    .s2_rdata_o      ( s2_rdata      ),
    .s2_low_o        ( s2_low        ),
    .s2_size_o       ( s2_size       ),
    .s2_sign_o       ( s2_sign       ),
    .s2_sc_o         ( s2_sc         ),
    .s2_sc_fail_o    ( s2_sc_fail    ),
    .s2_cause_o      ( s2_cause      )
);

amo_alu u_amo_alu (
    .amo_op_i        ( amo_op        ),
    .amo_src_i       ( amo_src       ),
    .amo_rdata_i     ( amo_rdata     ),
    .amo_wdata_o     ( amo_wdata     )
);

lsu_format u_format (
    .clk             ( clk           ),
    .rstn            ( rstn          ),
    .s2_valid_i      ( s2_valid      ),
    .s2_rdata_i      ( s2_rdata      ),
    .s2_low_i        ( s2_low        ),
    .s2_size_i       ( s2_size       ),
    .s2_sign_i       ( s2_sign       ),
    .s2_sc_i         ( s2_sc         ),
    .s2_sc_fail_i    ( s2_sc_fail    ),
    .s2_cause_i      ( s2_cause      ),
    .rsp_valid_o     ( rsp_valid_o   ),
    .rdata_o         ( rdata_o       ),
    .fault_o         ( fault_o       ),
    .cause_o         ( cause_o       )
);

dmem_model u_dmem (
    .clk             ( clk           ),
    .rstn            ( rstn          ),
    .req_i           ( dmem_req      ),
    .wr_i            ( dmem_wr       ),
    .addr_i          ( dmem_addr     ),
    .byte_i          ( dmem_byte     ),
    .wdata_i         ( dmem_wdata    ),
    .busy_o          ( dmem_busy     ),
    .rdata_o         ( dmem_rdata    ),
    .bad_o           ( dmem_bad      )
);

endmodule

//--- hdl/mem_pkg.sv
package mem_pkg;

// the array covers byte addresses 0x000 to 0x3FF.
localparam int DMEM_WORDS   = 256;
localparam int DMEM_IDX_LEN = 8;

localparam int MEM_WAIT     = 2;
localparam int WAIT_CNT_LEN = 2;

// stores into this window are refused.
localparam logic [lsu_pkg::ADDR_LEN-1:0] RO_BASE  = 12'h300;
localparam logic [lsu_pkg::ADDR_LEN-1:0] RO_LIMIT = 12'h3FF;

localparam int BAD_LEN   = 2;
localparam int BAD_PROT  = 0;
localparam int BAD_RANGE = 1;

endpackage

//--- lsu_top.f
hdl/lsu_pkg.sv
hdl/mem_pkg.sv
hdl/amo_alu.sv
hdl/lsu_align.sv
hdl/lsu_access.sv
hdl/lsu_format.sv
hdl/dmem_model.sv
hdl/lsu_top.sv
tests/lsu_props.sv
tests/lsu_checker.sv
tests/lsu_tb.sv

//--- tests/lsu_checker.sv
`timescale 1ns/100ps

module lsu_checker (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         req_i,
    input  logic                         wr_i,
    input  lsu_pkg::size_t               size_i,
    input  logic                         sign_ext_i,
    input  logic                         amo_i,
    input  logic                         lr_i,
    input  logic                         sc_i,
    input  lsu_pkg::amo_op_t             amo_op_i,
    input  logic [lsu_pkg::ADDR_LEN-1:0] addr_i,
    input  logic [lsu_pkg::XLEN-1:0]     wdata_i,
    input  logic                         busy_i,
    input  logic                         rsp_valid_i,
    input  logic [lsu_pkg::XLEN-1:0]     rdata_i,
    input  logic                         fault_i,
    input  lsu_pkg::cause_t              cause_i,
    output int                           chk_cnt_o,
    output int                           err_cnt_o,
    output int                           pend_o
);

import lsu_pkg::*;

logic [7:0]  mem_b [1024];
logic        resv_valid;
logic [9:0]  resv_word;
logic [31:0] exp_rdata_q[$];
logic        exp_fault_q[$];
logic [2:0]  exp_cause_q[$];

function automatic logic [31:0] word_at(input logic [11:0] a);
    return {mem_b[a + 3], mem_b[a + 2], mem_b[a + 1], mem_b[a]};
endfunction

function automatic logic [31:0] amo_calc(input logic [3:0] op, input logic [31:0] old,
                                          input logic [31:0] src);
    case (op)
        4'd1:    return old + src;
        4'd2:    return old ^ src;
        4'd3:    return old & src;
        4'd4:    return old | src;
        4'd5:    return ($signed(src) < $signed(old)) ? src : old;
        4'd6:    return ($signed(src) < $signed(old)) ? old : src;
        4'd7:    return (src < old) ? src : old;
        4'd8:    return (src < old) ? old : src;
        default: return src;
    endcase
endfunction

// ------------------------------
// prediction at the strobe
// ------------------------------
task automatic predict();
    logic [11:0] a;
    logic        st;
    logic        mis;
    logic        hit;
    logic        sc_fail;
    logic [31:0] d;
    logic [31:0] old;
    logic [2:0]  c;
    a = addr_i;
    st = wr_i | amo_i | sc_i;
    mis = ((size_i == SIZE_HALF) && a[0]) || ((size_i == SIZE_WORD) && (a[1:0] != 2'b00));
    hit = resv_valid && (resv_word == a[11:2]);
    sc_fail = sc_i && !hit;
    d = '0;
    c = CAUSE_NONE;
    if (sc_i || ((wr_i || amo_i) && hit)) resv_valid = 1'b0;
    if (mis) begin
        c = st ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED;
    end else if (sc_fail) begin
        d = 32'd1;
    end else if (a >= 12'h400) begin
        c = st ? CAUSE_STORE_ACCESS : CAUSE_LOAD_ACCESS;
    end else if (st && (a >= 12'h300)) begin
        c = CAUSE_STORE_PROTECT;
    end else if (amo_i) begin
        old = word_at(a);
        d = old;
        {mem_b[a + 3], mem_b[a + 2], mem_b[a + 1], mem_b[a]} = amo_calc(amo_op_i, old, wdata_i);
    end else if (st) begin
        mem_b[a] = wdata_i[7:0];
        if (size_i != SIZE_BYTE) mem_b[a + 1] = wdata_i[15:8];
        if (size_i == SIZE_WORD) begin
            mem_b[a + 2] = wdata_i[23:16];
            mem_b[a + 3] = wdata_i[31:24];
        end
    end else begin
        case (size_i)
            SIZE_BYTE: d = {{24{sign_ext_i & mem_b[a][7]}}, mem_b[a]};
            SIZE_HALF: d = {{16{sign_ext_i & mem_b[a + 1][7]}}, mem_b[a + 1], mem_b[a]};
            default:   d = word_at(a);
        endcase
        if (lr_i) begin
            resv_valid = 1'b1;
            resv_word = a[11:2];
        end
    end
    exp_rdata_q.push_back(d);
    exp_fault_q.push_back(c != CAUSE_NONE);
    exp_cause_q.push_back(c);
endtask

initial begin
    for (int i = 0; i < 1024; i++) begin
        mem_b[i] = 8'h00;
    end
    resv_valid = 1'b0;
    resv_word = '0;
    chk_cnt_o = 0;
    err_cnt_o = 0;
end

assign pend_o = exp_rdata_q.size();

// the response is compared before a new strobe in the same cycle is predicted.
always @(posedge clk) begin
    if (rstn && rsp_valid_i) begin
        chk_cnt_o++;
        if (exp_rdata_q.size() == 0) begin
            $display("response arrived with no request outstanding");
            err_cnt_o++;
        end else begin
            if (rdata_i !== exp_rdata_q[0]) begin
                $display("FAIL rdata_o expected %08h got %08h", exp_rdata_q[0], rdata_i);
                err_cnt_o++;
            end
            if (fault_i !== exp_fault_q[0]) begin
                $display("FAIL fault_o expected %0h got %0h", exp_fault_q[0], fault_i);
                err_cnt_o++;
            end
            if (cause_i !== exp_cause_q[0]) begin
                $display("FAIL cause_o expected %0h got %0h", exp_cause_q[0], cause_i);
                err_cnt_o++;
            end
            void'(exp_rdata_q.pop_front());
            void'(exp_fault_q.pop_front());
            void'(exp_cause_q.pop_front());
        end
    end
    if (rstn && req_i && !busy_i) begin
        predict();
    end
end

endmodule

//--- tests/lsu_props.sv
`timescale 1ns/100ps

module lsu_props (
    input logic        clk,
    input logic        rstn,
    input logic        req_i,
    input logic        wr_i,
    input logic        amo_i,
    input logic        lr_i,
    input logic        sc_i,
    input logic [1:0]  size_i,
    input logic [11:0] addr_i,
    input logic        busy_i,
    input logic        rsp_valid_i
);

logic plain_load;

// an aligned load inside the array goes through memory on the normal path.
assign plain_load = req_i && !wr_i && !amo_i && !lr_i && !sc_i && (addr_i < 12'h400) &&
                    !((size_i == 2'd1) && addr_i[0]) &&
                    !((size_i == 2'd2) && (addr_i[1:0] != 2'b00));

no_strobe_while_busy: assert property (@(posedge clk) disable iff (!rstn)
    req_i |-> !busy_i) else $error("strobe while busy");

busy_falls_with_rsp: assert property (@(posedge clk) disable iff (!rstn)
    rsp_valid_i |-> $fell(busy_i)) else $error("busy did not fall with the response");

load_latency: assert property (@(posedge clk) disable iff (!rstn)
    plain_load |-> ##6 rsp_valid_i) else $error("load response not on time");

endmodule

bind lsu_top lsu_props lsu_props_i (
    .clk         ( clk         ),
    .rstn        ( rstn        ),
    .req_i       ( req_i       ),
    .wr_i        ( wr_i        ),
    .amo_i       ( amo_i       ),
    .lr_i        ( lr_i        ),
    .sc_i        ( sc_i        ),
    .size_i      ( size_i      ),
    .addr_i      ( addr_i      ),
    .busy_i      ( busy_o      ),
    .rsp_valid_i ( rsp_valid_o )
);

//--- tests/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb;

import lsu_pkg::*;

localparam int N_REQ = 40 + 16 + 32 + 36 + 36;
localparam int LIMIT = N_REQ * 10 + 100;

logic        clk;
logic        rstn;
logic        req_i;
logic        wr_i;
size_t       size_i;
logic        sign_ext_i;
logic        amo_i;
logic        lr_i;
logic        sc_i;
amo_op_t     amo_op_i;
logic [11:0] addr_i;
logic [31:0] wdata_i;
logic        busy_o;
logic        rsp_valid_o;
logic [31:0] rdata_o;
logic        fault_o;
cause_t      cause_o;
int          chk_cnt;
int          err_cnt;
int          pend;
int          seed;
int          cycles;
int          last_chk;
int          last_err;
logic [31:0] r;
logic [11:0] a;

lsu_top lsu_top_i (.*);

lsu_checker checker_i (
    .clk (clk), .rstn (rstn), .req_i (req_i), .wr_i (wr_i), .size_i (size_i),
    .sign_ext_i (sign_ext_i), .amo_i (amo_i), .lr_i (lr_i), .sc_i (sc_i),
    .amo_op_i (amo_op_i), .addr_i (addr_i), .wdata_i (wdata_i), .busy_i (busy_o),
    .rsp_valid_i (rsp_valid_o), .rdata_i (rdata_o), .fault_i (fault_o),
    .cause_i (cause_o), .chk_cnt_o (chk_cnt), .err_cnt_o (err_cnt), .pend_o (pend)
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
        $display("timeout after %0d cycles", cycles);
        $display("Regression failed");
        $finish;
    end
end

task automatic send(input logic wr, input logic [1:0] sz, input logic sgn, input logic amo,
                    input logic lr, input logic sc, input logic [3:0] op,
                    input logic [11:0] addr, input logic [31:0] data);
    while (busy_o) @(negedge clk);
    req_i = 1'b1;
    wr_i = wr;
    size_i = size_t'(sz);
    sign_ext_i = sgn;
    amo_i = amo;
    lr_i = lr;
    sc_i = sc;
    amo_op_i = amo_op_t'(op);
    addr_i = addr;
    wdata_i = data;
    @(negedge clk);
    req_i = 1'b0;
endtask

// waits until the last response has been compared, then reports the test.
task automatic finish_test(input string name);
    while (busy_o) @(negedge clk);
    @(negedge clk);
    $display("%s done: %0d checks, %0d errors", name, chk_cnt - last_chk, err_cnt - last_err);
    last_chk = chk_cnt;
    last_err = err_cnt;
endtask

initial begin
    seed = 32'h3455;
    cycles = 0;
    last_chk = 0;
    last_err = 0;
    rstn = 1'b0;
    req_i = 1'b0;
    wr_i = 1'b0;
    size_i = SIZE_WORD;
    sign_ext_i = 1'b0;
    amo_i = 1'b0;
    lr_i = 1'b0;
    sc_i = 1'b0;
    amo_op_i = AMO_SWAP;
    addr_i = '0;
    wdata_i = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);

    // ------------------------------
    for (int i = 0; i < 40; i++) begin
        r = $random(seed);
        a = {6'd0, r[13:8]} &
            ~((r[1:0] == 2'd0) ? 12'h0 : ((r[1:0] == 2'd1) ? 12'h1 : 12'h3));
        send(i < 20, (r[1:0] == 2'd3) ? 2'd2 : r[1:0], r[2], 0, 0, 0, 0, a, $random(seed));
    end
    finish_test("aligned load/store");

    for (int i = 0; i < 8; i++) begin
        r = $random(seed);
        a = {6'd0, r[5:2], 2'b00};
        if (r[6]) send(r[7], 2'd1, 0, 0, 0, 0, 0, a | 12'h1, $random(seed));
        else send(r[7], 2'd2, 0, 0, 0, 0, 0,
                  a | ((r[1:0] == 2'd0) ? 12'h2 : {10'd0, r[1:0]}), r);
        send(0, 2'd2, 0, 0, 0, 0, 0, a, 0);
    end
    finish_test("misaligned");

    for (int i = 0; i < 8; i++) begin
        r = $random(seed);
        send(0, 2'd2, 0, 0, 0, 0, 0, 12'h400 + (r[11:0] & 12'hBFC), 0);
        send(1, 2'd2, 0, 0, 0, 0, 0, 12'h400 + (r[23:12] & 12'hBFC), r);
        send(1, 2'd2, 0, 0, 0, 0, 0, 12'h300 + {4'd0, r[7:0] & 8'hFC}, ~r);
        send(0, 2'd2, 0, 0, 0, 0, 0, 12'h300 + {4'd0, r[7:0] & 8'hFC}, 0);
    end
    finish_test("access and protect");

    for (int i = 0; i < 18; i++) begin
        r = $random(seed);
        a = {6'd0, r[5:2], 2'b00};
        send(0, 2'd2, 0, 1, 0, 0, 4'(i % 9), a, $random(seed));
        send(0, 2'd2, 0, 0, 0, 0, 0, a, 0);
    end
    finish_test("amo");

    for (int i = 0; i < 4; i++) begin
        r = $random(seed);
        a = 12'h040 + {6'd0, r[3:0], 2'b00};
        send(0, 2'd2, 0, 0, 1, 0, 0, a, 0);
        send(1, 2'd2, 0, 0, 0, 1, 0, a, r);
        send(0, 2'd2, 0, 0, 0, 0, 0, a, 0);
        send(1, 2'd2, 0, 0, 0, 1, 0, a, ~r);
        send(0, 2'd2, 0, 0, 0, 0, 0, a, 0);
        send(0, 2'd2, 0, 0, 1, 0, 0, a, 0);
        send(1, 2'd0, 0, 0, 0, 0, 0, a, r ^ 32'h5a);
        send(1, 2'd2, 0, 0, 0, 1, 0, a, 32'hffff_0000);
        send(0, 2'd2, 0, 0, 0, 0, 0, a, 0);
    end
    finish_test("lr/sc");

    if (pend != 0) begin
        $display("%0d responses never arrived", pend);
    end
    $display("total: %0d checks, %0d errors", chk_cnt, err_cnt);
    if ((err_cnt == 0) && (pend == 0)) begin
        $display("Regression passed");
    end else begin
        $display("Regression failed");
    end
    $finish;
end

endmodule
